// ==== src/bpu_cfg_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// BPU configuration constants
// Address width, fetch width, table depths, reset PC, credit count
// and the widths derived from them
//////////////////////////////////////////////////////////////////////
`default_nettype none

package bpu_cfg_pkg;

    // Core sizes
    localparam int ADDR_WIDTH  = 32;
    localparam int FETCH_WIDTH = 4;
    localparam int FTB_DEPTH   = 64;
    localparam int BHT_DEPTH   = 256;
    localparam int FTQ_CREDITS = 4;
    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h0000_1000;

    // Counter row, reset to weakly not taken
    localparam int BHT_CTR_WIDTH = 2;
    localparam logic [BHT_CTR_WIDTH-1:0] BHT_CTR_INIT = 2'b01;

    // Derived widths
    localparam int SLOT_WIDTH      = $clog2(FETCH_WIDTH);
    localparam int BLOCK_OFF_WIDTH = SLOT_WIDTH + 2;
    localparam int FTB_IDX_WIDTH   = $clog2(FTB_DEPTH);
    localparam int BHT_IDX_WIDTH   = $clog2(BHT_DEPTH);
    localparam int TAG_WIDTH       = ADDR_WIDTH - FTB_IDX_WIDTH - BLOCK_OFF_WIDTH;
    localparam int LEN_WIDTH       = $clog2(FETCH_WIDTH + 1);
    localparam int CREDIT_WIDTH    = $clog2(FTQ_CREDITS + 1);

    // 4 KB page, cut blocks that start in the last line
    localparam int PAGE_OFF_WIDTH = 12;
    localparam logic [PAGE_OFF_WIDTH-1:0] PAGE_CUT_PC = 12'hFF0;

endpackage

`default_nettype wire

// ==== src/bpu_types_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// BPU data types
// FTB entry, FTQ block, training meta, redirect and decoded PC,
// plus the PC decode used by the PC generator and both tables
//////////////////////////////////////////////////////////////////////
`default_nettype none

package bpu_types_pkg;

    import bpu_cfg_pkg::*;

    // One FTB row, one branch per fetch block
    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        logic [SLOT_WIDTH-1:0] slot;
        logic [ADDR_WIDTH-1:0] target;
    } ftb_entry_t;

    // Block sent to the FTQ
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] start_pc;
        logic [LEN_WIDTH-1:0]  length;
        logic                  taken;
        logic [ADDR_WIDTH-1:0] next_pc;
        logic                  is_cross_cacheline;
    } bpu_ftq_t;

    // Resolved branch coming back from the FTQ
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] pc;
        logic                  taken;
        logic [ADDR_WIDTH-1:0] target;
    } ftq_bpu_meta_t;

    // Back end redirect
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] pc;
    } ftq_redirect_t;

    // PC split into table index and tag
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]    pc;
        logic [FTB_IDX_WIDTH-1:0] ftb_idx;
        logic [TAG_WIDTH-1:0]     ftb_tag;
        logic [BHT_IDX_WIDTH-1:0] bht_idx;
    } pc_dec_t;

    // Both tables index by block, so a branch and its block start share rows
    function automatic pc_dec_t decode_pc(input logic [ADDR_WIDTH-1:0] pc);
        pc_dec_t dec;
        dec.pc      = pc;
        dec.ftb_idx = pc[BLOCK_OFF_WIDTH +: FTB_IDX_WIDTH];
        dec.ftb_tag = pc[ADDR_WIDTH-1 -: TAG_WIDTH];
        dec.bht_idx = pc[BLOCK_OFF_WIDTH +: BHT_IDX_WIDTH];
        return dec;
    endfunction

endpackage

`default_nettype wire

// ==== src/bpu_table.sv ====
//////////////////////////////////////////////////////////////////////
// Direct-mapped BPU storage array
// Combinational read, synchronous write, reset of every row
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module bpu_table #(
    parameter type    entry_t     = logic,
    parameter int     DEPTH       = 2,
    parameter entry_t RESET_VALUE = '0
) (
    input  logic                     clk,
    input  logic                     rst_i,
    // Lookup port
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_data_o,
    // Training port
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i
);

    entry_t mem [DEPTH];

    // Reset clears all rows in one cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VALUE;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // Same-cycle lookup, a write shows up from the next cycle on
    assign rd_data_o = mem[rd_idx_i];

    // Training index must land inside the array
    a_wr_idx_range: assert property (@(posedge clk) disable iff (rst_i)
        wr_en_i |-> (int'(wr_idx_i) < DEPTH));

endmodule

`default_nettype wire

// ==== src/bpu_pc_gen.sv ====
//////////////////////////////////////////////////////////////////////
// BPU PC generator, decode stage
// Fetch PC register, FTQ credit counter and PC decode
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module bpu_pc_gen (
    input  logic                                 clk,
    input  logic                                 rst_i,
    output logic                                 issue_ok_o,
    output bpu_types_pkg::pc_dec_t               pc_dec_o,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]   next_pc_i,
    input  logic                                 credit_return_i,
    input  bpu_types_pkg::ftq_redirect_t         redirect_i
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic [ADDR_WIDTH-1:0]   pc_q;
    logic [CREDIT_WIDTH-1:0] credits_q;

    //////////////////////////////////////////////////////////////////////
    // Issue and credits
    //////////////////////////////////////////////////////////////////////

    // Issue needs a free FTQ slot and no redirect
    assign issue_ok_o = !rst_i && (credits_q != '0) && !redirect_i.valid;

    // Spend on issue and refill on return
    // Both in one cycle leave the count as is
    always_ff @(posedge clk) begin
        if (rst_i) begin
            credits_q <= CREDIT_WIDTH'(FTQ_CREDITS);
        end else if (issue_ok_o && !credit_return_i) begin
            credits_q <= credits_q - 1'b1;
        end else if (credit_return_i && !issue_ok_o) begin
            credits_q <= credits_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch PC
    //////////////////////////////////////////////////////////////////////

    // Redirect first, then the predicted next PC, else hold
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.pc;
        end else if (issue_ok_o) begin
            pc_q <= next_pc_i;
        end
    end

    // Index and tag for the lookup tables
    assign pc_dec_o = decode_pc(pc_q);

    // FTQ never gets back more slots than it has
    a_credit_bound: assert property (@(posedge clk) disable iff (rst_i)
        credits_q <= CREDIT_WIDTH'(FTQ_CREDITS));

endmodule

`default_nettype wire

// ==== src/ftb.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch target buffer, execute stage
// Tag compare, hit flag and training write of taken branches
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ftb (
    input  logic                          clk,
    input  logic                          rst_i,
    // Lookup
    input  bpu_types_pkg::pc_dec_t        query_i,
    output logic                          hit_o,
    output bpu_types_pkg::ftb_entry_t     entry_o,
    // Training
    input  bpu_types_pkg::ftq_bpu_meta_t  meta_i
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    ftb_entry_t rd_entry;
    ftb_entry_t wr_entry;
    pc_dec_t    meta_dec;
    logic       wr_en;

    // Only taken branches allocate
    assign meta_dec = decode_pc(meta_i.pc);
    assign wr_en    = meta_i.valid && meta_i.taken;

    // New row for the branch block
    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = meta_dec.ftb_tag;
        // Word of the branch inside its block
        wr_entry.slot   = meta_i.pc[BLOCK_OFF_WIDTH-1:2];
        wr_entry.target = meta_i.target;
    end

    bpu_table #(
        .entry_t    (ftb_entry_t),
        .DEPTH      (FTB_DEPTH),
        .RESET_VALUE('0)
    ) i_ftb_table (
        .clk      (clk),
        .rst_i    (rst_i),
        .rd_idx_i (query_i.ftb_idx),
        .rd_data_o(rd_entry),
        .wr_en_i  (wr_en),
        .wr_idx_i (meta_dec.ftb_idx),
        .wr_data_i(wr_entry)
    );

    // Hit on valid row with matching tag
    assign hit_o   = rd_entry.valid && (rd_entry.tag == query_i.ftb_tag);
    assign entry_o = rd_entry;

endmodule

`default_nettype wire

// ==== src/bimodal_predictor.sv ====
//////////////////////////////////////////////////////////////////////
// Bimodal direction predictor, execute stage
// 2-bit saturating counters with lookup and training update
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module bimodal_predictor (
    input  logic                          clk,
    input  logic                          rst_i,
    input  bpu_types_pkg::pc_dec_t        query_i,
    output logic                          taken_o,
    input  bpu_types_pkg::ftq_bpu_meta_t  meta_i
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    typedef logic [BHT_CTR_WIDTH-1:0] bht_ctr_t;

    pc_dec_t  meta_dec;
    bht_ctr_t query_ctr;
    bht_ctr_t train_ctr;
    bht_ctr_t train_next;

    assign meta_dec = decode_pc(meta_i.pc);

    // Saturating step toward the resolved direction
    always_comb begin
        train_next = train_ctr;
        if (meta_i.taken) begin
            if (train_ctr != '1) begin
                train_next = train_ctr + 1'b1;
            end
        end else if (train_ctr != '0) begin
            train_next = train_ctr - 1'b1;
        end
    end

    // Lookup copy
    bpu_table #(
        .entry_t    (bht_ctr_t),
        .DEPTH      (BHT_DEPTH),
        .RESET_VALUE(BHT_CTR_INIT)
    ) i_bht_query (
        .clk      (clk),
        .rst_i    (rst_i),
        .rd_idx_i (query_i.bht_idx),
        .rd_data_o(query_ctr),
        .wr_en_i  (meta_i.valid),
        .wr_idx_i (meta_dec.bht_idx),
        .wr_data_i(train_next)
    );

    // Training copy, same writes, read at the meta index
    bpu_table #(
        .entry_t    (bht_ctr_t),
        .DEPTH      (BHT_DEPTH),
        .RESET_VALUE(BHT_CTR_INIT)
    ) i_bht_train (
        .clk      (clk),
        .rst_i    (rst_i),
        .rd_idx_i (meta_dec.bht_idx),
        .rd_data_o(train_ctr),
        .wr_en_i  (meta_i.valid),
        .wr_idx_i (meta_dec.bht_idx),
        .wr_data_i(train_next)
    );

    // MSB is the direction
    assign taken_o = query_ctr[BHT_CTR_WIDTH-1];

endmodule

`default_nettype wire

// ==== src/ftq_block_gen.sv ====
//////////////////////////////////////////////////////////////////////
// FTQ block generator, result stage
// Block length, taken flag, next PC and the page-end cut
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ftq_block_gen (
    input  bpu_types_pkg::pc_dec_t     query_i,
    input  logic                       issue_ok_i,
    input  logic                       ftb_hit_i,
    input  bpu_types_pkg::ftb_entry_t  ftb_entry_i,
    input  logic                       taken_i,
    output bpu_types_pkg::bpu_ftq_t    block_o
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic [SLOT_WIDTH-1:0]     word_off;
    logic [LEN_WIDTH-1:0]      words_left;
    logic [PAGE_OFF_WIDTH-1:0] page_bytes;
    logic [LEN_WIDTH-1:0]      page_words;
    logic                      is_cross_page;
    logic [LEN_WIDTH-1:0]      seq_len;
    logic [LEN_WIDTH-1:0]      br_len;
    logic                      br_taken;

    // Word position of the PC in its 16-byte line
    assign word_off   = query_i.pc[BLOCK_OFF_WIDTH-1:2];
    assign words_left = LEN_WIDTH'(FETCH_WIDTH) - LEN_WIDTH'(word_off);

    // Bytes up to the 4 KB boundary, only meaningful near page end
    assign page_bytes    = '0 - query_i.pc[PAGE_OFF_WIDTH-1:0];
    assign page_words    = LEN_WIDTH'(page_bytes >> 2);
    assign is_cross_page = query_i.pc[PAGE_OFF_WIDTH-1:0] > PAGE_CUT_PC;

    // Sequential block length
    always_comb begin
        seq_len = words_left;
        if (is_cross_page && (page_words < words_left)) begin
            seq_len = page_words;
        end
    end

    // Branch must sit at or after the block start
    assign br_taken = ftb_hit_i && taken_i && (ftb_entry_i.slot >= word_off);
    assign br_len   = LEN_WIDTH'(ftb_entry_i.slot) - LEN_WIDTH'(word_off) + LEN_WIDTH'(1);

    //////////////////////////////////////////////////////////////////////
    // Block assembly
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        block_o.valid    = issue_ok_i;
        block_o.start_pc = query_i.pc;
        if (br_taken) begin
            block_o.length  = br_len;
            block_o.taken   = 1'b1;
            block_o.next_pc = ftb_entry_i.target;
        end else begin
            block_o.length  = seq_len;
            block_o.taken   = 1'b0;
            block_o.next_pc = query_i.pc + ADDR_WIDTH'({seq_len, 2'b00});
        end
        // Blocks stop at the line end, so never cross it
        block_o.is_cross_cacheline = 1'b0;
    end

endmodule

`default_nettype wire

// ==== src/bpu.sv ====
//////////////////////////////////////////////////////////////////////
// Branch prediction unit top
// PC generator, FTB, bimodal predictor and FTQ block generator
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module bpu (
    input  logic                          clk,
    input  logic                          rst_i,
    // Prediction toward the FTQ
    output bpu_types_pkg::bpu_ftq_t       ftq_predict_o,
    input  logic                          credit_return_i,
    // Training and redirect from the FTQ
    input  bpu_types_pkg::ftq_bpu_meta_t  ftq_meta_i,
    input  bpu_types_pkg::ftq_redirect_t  redirect_i
);

    import bpu_types_pkg::*;

    pc_dec_t    pc_dec;
    logic       issue_ok;
    logic       ftb_hit;
    ftb_entry_t ftb_entry;
    logic       bht_taken;

    // Decode
    bpu_pc_gen i_pc_gen (
        .clk            (clk),
        .rst_i          (rst_i),
        .issue_ok_o     (issue_ok),
        .pc_dec_o       (pc_dec),
        .next_pc_i      (ftq_predict_o.next_pc),
        .credit_return_i(credit_return_i),
        .redirect_i     (redirect_i)
    );

    // Execute
    ftb i_ftb (
        .clk    (clk),
        .rst_i  (rst_i),
        .query_i(pc_dec),
        .hit_o  (ftb_hit),
        .entry_o(ftb_entry),
        .meta_i (ftq_meta_i)
    );

    bimodal_predictor i_bimodal (
        .clk    (clk),
        .rst_i  (rst_i),
        .query_i(pc_dec),
        .taken_o(bht_taken),
        .meta_i (ftq_meta_i)
    );

    // Result
    ftq_block_gen i_block_gen (
        .query_i    (pc_dec),
        .issue_ok_i (issue_ok),
        .ftb_hit_i  (ftb_hit),
        .ftb_entry_i(ftb_entry),
        .taken_i    (bht_taken),
        .block_o    (ftq_predict_o)
    );

endmodule

`default_nettype wire

// ==== test/bpu_tests.svh ====
//////////////////////////////////////////////////////////////////////
// Directed tests for the branch prediction unit
// Value and block checks, wait and credit helpers, and one task per
// behavior: sequential fetch, page cut, back-pressure, training,
// redirect priority
//////////////////////////////////////////////////////////////////////

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
        else fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
endtask

// DUT block against the model
task automatic check_block(input logic exp_valid, input logic [LEN_WIDTH-1:0] len,
                           input logic tk, input logic [ADDR_WIDTH-1:0] nxt);
    check_val("ftq_predict_o.valid", 32'(ftq_predict_o.valid), 32'(exp_valid));
    check_val("ftq_predict_o.start_pc", ftq_predict_o.start_pc, ref_pc);
    if (exp_valid) begin
        check_val("ftq_predict_o.length", 32'(ftq_predict_o.length), 32'(len));
        check_val("ftq_predict_o.taken", 32'(ftq_predict_o.taken), 32'(tk));
        check_val("ftq_predict_o.next_pc", ftq_predict_o.next_pc, nxt);
        check_val("ftq_predict_o.is_cross_cacheline",
                  32'(ftq_predict_o.is_cross_cacheline), 0);
    end
endtask

// Run cycles until a block issues
task automatic wait_block(input int limit);
    int n;
    n = 0;
    run_cycle();
    while (!last_issue) begin
        n++;
        assert (n < limit) else fail_run("No block issued within the wait limit");
        run_cycle();
    end
endtask

task automatic redirect_to(input logic [ADDR_WIDTH-1:0] pc);
    redirect_i.valid = 1'b1;
    redirect_i.pc    = pc;
    run_cycle();
endtask

// Redirect cycles never issue so each return adds a credit
task automatic refill_credits(input logic [ADDR_WIDTH-1:0] pc);
    while (ref_credits < FTQ_CREDITS) begin
        credit_return_i = 1'b1;
        redirect_to(pc);
    end
endtask

task automatic seq_fetch_test();
    for (int k = 0; k < 6; k++) begin
        credit_return_i = 1'b1;
        run_cycle();
        check_val("ftq_predict_o.valid", 32'(last_blk.valid), 1);
        check_val("ftq_predict_o.start_pc", last_blk.start_pc, RESET_PC + 32'(16 * k));
        check_val("ftq_predict_o.length", 32'(last_blk.length), 4);
        check_val("ftq_predict_o.taken", 32'(last_blk.taken), 0);
    end
endtask

task automatic page_cut_test();
    logic [31:0] rnd;
    logic [31:0] pc;
    int          words;
    for (int k = 0; k < 8; k++) begin
        rnd = $urandom();
        // Word aligned PC above FF0 in a random page
        pc = {rnd[31:12], 12'hFF0 + 12'(4 * (1 + int'(rnd[3:0]) % 3))};
        words = (4096 - int'(pc[11:0])) / 4;
        redirect_to(pc);
        credit_return_i = 1'b1;
        run_cycle();
        check_val("ftq_predict_o.start_pc", last_blk.start_pc, pc);
        check_val("ftq_predict_o.length", 32'(last_blk.length), words);
        check_val("ftq_predict_o.next_pc", last_blk.next_pc, pc + 32'(4 * words));
        check_val("ftq_predict_o.is_cross_cacheline", 32'(last_blk.is_cross_cacheline), 0);
    end
    // Unaligned start with two words left in the line
    redirect_to(32'h0000_2008);
    credit_return_i = 1'b1;
    run_cycle();
    check_val("ftq_predict_o.length", 32'(last_blk.length), 2);
    check_val("ftq_predict_o.next_pc", last_blk.next_pc, 32'h0000_2010);
endtask

task automatic backpressure_test();
    int          issued;
    logic [31:0] held_pc;
    issued = 0;
    run_cycle();
    while (last_issue) begin
        issued++;
        assert (issued <= FTQ_CREDITS) else fail_run("Blocks kept issuing with no credits");
        run_cycle();
    end
    check_val("issued blocks", issued, FTQ_CREDITS);
    // Model PC after the last issued block
    held_pc = ref_pc;
    repeat (3) begin
        run_cycle();
        check_val("ftq_predict_o.valid", 32'(last_blk.valid), 0);
        check_val("ftq_predict_o.start_pc", last_blk.start_pc, held_pc);
    end
    // A single return releases one more block
    credit_return_i = 1'b1;
    wait_block(4);
    check_val("ftq_predict_o.start_pc", last_blk.start_pc, held_pc);
    run_cycle();
    check_val("ftq_predict_o.valid", 32'(last_blk.valid), 0);
    refill_credits(32'h0000_2000);
endtask

task automatic training_test();
    logic [31:0] blk_pc;
    logic [31:0] target;
    blk_pc = 32'h0000_3000;
    target = 32'h0000_5040;
    // Taken branch in slot 2
    ftq_meta_i.valid  = 1'b1;
    ftq_meta_i.pc     = blk_pc + 32'd8;
    ftq_meta_i.taken  = 1'b1;
    ftq_meta_i.target = target;
    redirect_to(blk_pc);
    credit_return_i = 1'b1;
    run_cycle();
    check_val("ftq_predict_o.length", 32'(last_blk.length), 3);
    check_val("ftq_predict_o.taken", 32'(last_blk.taken), 1);
    check_val("ftq_predict_o.next_pc", last_blk.next_pc, target);
    credit_return_i = 1'b1;
    run_cycle();
    check_val("ftq_predict_o.start_pc", last_blk.start_pc, target);
    // Two not-taken outcomes push the counter below the taken half
    repeat (2) begin
        ftq_meta_i.valid  = 1'b1;
        ftq_meta_i.pc     = blk_pc + 32'd8;
        ftq_meta_i.taken  = 1'b0;
        ftq_meta_i.target = target;
        redirect_to(blk_pc);
    end
    credit_return_i = 1'b1;
    run_cycle();
    check_val("ftq_predict_o.length", 32'(last_blk.length), 4);
    check_val("ftq_predict_o.taken", 32'(last_blk.taken), 0);
    check_val("ftq_predict_o.next_pc", last_blk.next_pc, blk_pc + 32'd16);
endtask

task automatic redirect_priority_test();
    int issued;
    run_cycle();
    redirect_to(32'h0000_7000);
    check_val("ftq_predict_o.valid", 32'(last_blk.valid), 0);
    issued = 0;
    run_cycle();
    check_val("ftq_predict_o.start_pc", last_blk.start_pc, 32'h0000_7000);
    while (last_issue) begin
        issued++;
        assert (issued <= FTQ_CREDITS) else fail_run("Blocks kept issuing with no credits");
        run_cycle();
    end
    // Redirect cycle spent no credit
    check_val("blocks issued after redirect", issued, FTQ_CREDITS - 1);
endtask

// ==== test/tb_bpu.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the branch prediction unit
// Clock, reset, DUT instance, watchdog, reference model of the
// counters, the FTB and the block rule, and the test sequence
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_bpu;

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DLY       = 2;
    localparam int RESET_CYCLES    = 10;
    localparam int EXP_BLOCKS      = 30;
    localparam int WATCHDOG_CYCLES = EXP_BLOCKS * 20 + 200;
    localparam logic [31:0] SEED   = 32'h50145187;
    // 16-byte fetch line
    localparam int LINE_BITS       = 4;

    logic          clk;
    logic          rst_i;
    bpu_ftq_t      ftq_predict_o;
    logic          credit_return_i;
    ftq_bpu_meta_t ftq_meta_i;
    ftq_redirect_t redirect_i;

    // Reference model state
    logic [ADDR_WIDTH-1:0] ref_pc;
    int                    ref_credits;
    logic [1:0]            m_ctr    [BHT_DEPTH];
    logic                  m_valid  [FTB_DEPTH];
    logic [TAG_WIDTH-1:0]  m_tag    [FTB_DEPTH];
    int                    m_slot   [FTB_DEPTH];
    logic [ADDR_WIDTH-1:0] m_target [FTB_DEPTH];

    // Block seen in the last cycle
    bpu_ftq_t last_blk;
    logic     last_issue;

    bpu i_dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .ftq_predict_o  (ftq_predict_o),
        .credit_return_i(credit_return_i),
        .ftq_meta_i     (ftq_meta_i),
        .redirect_i     (redirect_i)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Watchdog expired before the test sequence finished");
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic void model_reset();
        for (int i = 0; i < BHT_DEPTH; i++) begin
            m_ctr[i] = 2'b01;
        end
        for (int i = 0; i < FTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        ref_pc      = RESET_PC;
        ref_credits = FTQ_CREDITS;
    endfunction

    // Expected block for a fetch PC
    function automatic void predict_block(input logic [ADDR_WIDTH-1:0] pc,
                                          output logic [LEN_WIDTH-1:0] len,
                                          output logic tk,
                                          output logic [ADDR_WIDTH-1:0] nxt);
        int off;
        int left;
        int page_left;
        int fi;
        int bi;
        off = int'(pc[3:2]);
        left = FETCH_WIDTH - off;
        fi = int'(pc[LINE_BITS +: FTB_IDX_WIDTH]);
        bi = int'(pc[LINE_BITS +: BHT_IDX_WIDTH]);
        if (m_valid[fi] && (m_tag[fi] == pc[ADDR_WIDTH-1 -: TAG_WIDTH]) &&
            m_ctr[bi][1] && (m_slot[fi] >= off)) begin
            len = LEN_WIDTH'(m_slot[fi] - off + 1);
            tk  = 1'b1;
            nxt = m_target[fi];
        end else begin
            len = LEN_WIDTH'(left);
            // Near the 4 KB boundary
            if (pc[11:0] > 12'hFF0) begin
                page_left = (4096 - int'(pc[11:0])) / 4;
                if (page_left < left) begin
                    len = LEN_WIDTH'(page_left);
                end
            end
            tk  = 1'b0;
            nxt = pc + ADDR_WIDTH'(4 * int'(len));
        end
    endfunction

    function automatic void train_model(input ftq_bpu_meta_t m);
        int bi;
        int fi;
        bi = int'(m.pc[LINE_BITS +: BHT_IDX_WIDTH]);
        fi = int'(m.pc[LINE_BITS +: FTB_IDX_WIDTH]);
        if (m.taken) begin
            if (m_ctr[bi] != 2'b11) begin
                m_ctr[bi] = m_ctr[bi] + 2'b01;
            end
            m_valid[fi]  = 1'b1;
            m_tag[fi]    = m.pc[ADDR_WIDTH-1 -: TAG_WIDTH];
            m_slot[fi]   = int'(m.pc[3:2]);
            m_target[fi] = m.target;
        end else if (m_ctr[bi] != 2'b00) begin
            m_ctr[bi] = m_ctr[bi] - 2'b01;
        end
    endfunction

    // One clock: check at the falling edge, then follow the rising edge
    task automatic run_cycle();
        logic                  issue;
        logic                  ret;
        ftq_redirect_t         redir;
        ftq_bpu_meta_t         meta;
        logic [LEN_WIDTH-1:0]  len;
        logic                  tk;
        logic [ADDR_WIDTH-1:0] nxt;
        @(negedge clk);
        ret   = credit_return_i;
        redir = redirect_i;
        meta  = ftq_meta_i;
        issue = (ref_credits != 0) && !redir.valid;
        predict_block(ref_pc, len, tk, nxt);
        check_block(issue, len, tk, nxt);
        last_blk   = ftq_predict_o;
        last_issue = issue;
        @(posedge clk);
        if (meta.valid) begin
            train_model(meta);
        end
        if (redir.valid) begin
            ref_pc = redir.pc;
        end else if (issue) begin
            ref_pc = nxt;
        end
        if (issue && !ret) begin
            ref_credits--;
        end else if (ret && !issue) begin
            ref_credits++;
        end
        #DRIVE_DLY;
        credit_return_i = 1'b0;
        ftq_meta_i      = '0;
        redirect_i      = '0;
    endtask

    `include "bpu_tests.svh"

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(SEED));
        rst_i           = 1'b1;
        credit_return_i = 1'b0;
        ftq_meta_i      = '0;
        redirect_i      = '0;
        last_issue      = 1'b0;
        last_blk        = '0;
        model_reset();
        // No blocks while in reset
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_val("ftq_predict_o.valid", 32'(ftq_predict_o.valid), 0);
        end
        @(posedge clk);
        #DRIVE_DLY;
        rst_i = 1'b0;
        seq_fetch_test();
        page_cut_test();
        backpressure_test();
        training_test();
        redirect_priority_test();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+test
src/bpu_cfg_pkg.sv
src/bpu_types_pkg.sv
src/bpu_table.sv
src/bpu_pc_gen.sv
src/ftb.sv
src/bimodal_predictor.sv
src/ftq_block_gen.sv
src/bpu.sv
test/tb_bpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the BPU testbench with Verilator and run it
# Exit status is the verdict of the run

cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_bpu -Mdir obj_dir -f tb.f \
    && ./obj_dir/Vtb_bpu \
    || exit 1
